// ==== files.f ====
src/nes_timing_pkg.sv
src/nes_pad_pkg.sv
src/nes_poll_sequencer.sv
src/nes_serial_capture.sv
src/nes_button_events.sv
src/nes_pad_top.sv
verif/nes_pad_assert.sv
verif/nes_pad_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NES pad testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=nes_pad_sim

# Compile, assertions and timing enabled
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module nes_pad_tb \
	-Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

# Run, keep the log for the search below
"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$log_file"; then
	echo "Simulation FAILED"
	exit 1
fi

# A run that ended without any verdict also counts as failed
if ! grep -q "Finished with no errors" "$log_file"; then
	echo "Simulation gave no verdict"
	exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== verif/nes_pad_tb.sv ====
`timescale 1ns/1ps

module nes_pad_tb;

	import nes_timing_pkg::*;
	import nes_pad_pkg::*;

	// Short frames keep the run quick
	localparam int tb_poll_cycles = 6000;
	localparam int clk_period_ns  = 20;
	localparam int reset_cycles   = 5;
	localparam int fixed_entries  = 10;
	localparam int random_entries = 6;
	localparam int entries        = fixed_entries + random_entries;
	// Frame valid lags the eighth pulse fall by two clocks
	localparam int valid_delay    = 2;
	localparam int watchdog_ns    = (entries + 2) * tb_poll_cycles * clk_period_ns;

	// DUT pins
	logic                clk_50M;
	logic                arst_n;
	logic                data;
	logic                latch;
	logic                pulse;
	logic [pad_bits-1:0] buttons;
	logic [pad_bits-1:0] pressed;
	logic [pad_bits-1:0] released;
	logic                frame_valid;

	// Stimulus and expected columns
	logic [pad_bits-1:0] stim_pattern [entries];
	logic [pad_bits-1:0] exp_buttons  [entries];
	logic [pad_bits-1:0] exp_pressed  [entries];
	logic [pad_bits-1:0] exp_released [entries];

	// Pad model state
	logic [pad_bits-1:0] pad_pattern = '0;
	logic [pad_bits-1:0] pad_shift   = '0;
	int                  pad_left    = 0;
	logic                pad_pulse_q = 1'b1;

	// Protocol monitor state
	int                  cycle_no        = 0;
	int                  latch_rises     = 0;
	int                  latch_len       = 0;
	int                  fall_count      = 0;
	int                  low_len         = 0;
	int                  last_fall_cycle = 0;
	int                  frames_seen     = 0;
	logic                latch_q         = 1'b0;
	logic                pulse_q         = 1'b1;
	// Expected buttons of the last completed frame
	logic [pad_bits-1:0] held_buttons    = '0;

	int                  check_count = 0;
	int                  error_count = 0;
	logic [31:0]         lfsr_state  = 32'h9624_bd61;

	nes_pad_top #(
		.poll_cycles (tb_poll_cycles)
	) dut_i (
		.clk_50M     (clk_50M),
		.arst_n      (arst_n),
		.data        (data),
		.latch       (latch),
		.pulse       (pulse),
		.buttons     (buttons),
		.pressed     (pressed),
		.released    (released),
		.frame_valid (frame_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_byte(input string name, input logic [pad_bits-1:0] expected,
		input logic [pad_bits-1:0] actual);
		check_count++;
		assert (actual == expected)
		else
		begin
			error_count++;
			$display("Mismatch at %0t: %s expected %02h, got %02h",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		check_count++;
		assert (actual == expected)
		else
		begin
			error_count++;
			$display("Mismatch at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual);
		end
	endtask

	// Galois form shifting right with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'hA300_0000;
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_byte(output logic [pad_bits-1:0] value);
		value = '0;
		for (int b = 0; b < pad_bits; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[pad_bits-2:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [pad_bits-1:0] button_mask(input button_e btn);
		return pad_bits'(1) << btn;
	endfunction

	task automatic build_table();
		logic [pad_bits-1:0] prev;
		logic [pad_bits-1:0] value;
		prev = '0;
		stim_pattern[0] = 8'h00;
		stim_pattern[1] = 8'hFF;
		stim_pattern[2] = button_mask(btn_a);
		stim_pattern[3] = button_mask(btn_right);
		stim_pattern[4] = button_mask(btn_up);
		stim_pattern[5] = 8'hAA;
		stim_pattern[6] = 8'h55;
		// Repeat with no events expected
		stim_pattern[7] = 8'h55;
		stim_pattern[8] = button_mask(btn_start) | button_mask(btn_select);
		// Everything let go
		stim_pattern[9] = 8'h00;
		for (int i = fixed_entries; i < entries; i++)
		begin
			random_byte(value);
			stim_pattern[i] = value;
		end
		// Edges against the previous frame or zero for the first
		for (int i = 0; i < entries; i++)
		begin
			exp_buttons[i]  = stim_pattern[i];
			exp_pressed[i]  = stim_pattern[i] & ~prev;
			exp_released[i] = prev & ~stim_pattern[i];
			prev            = stim_pattern[i];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock, pad model and protocol monitor
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk_50M = 1'b0;
		forever #(clk_period_ns / 2) clk_50M = ~clk_50M;
	end

	// Loads on latch and shifts on each pulse rise with A first
	always @(negedge clk_50M)
	begin
		if (latch)
		begin
			pad_shift = pad_pattern;
			pad_left  = pad_bits;
		end
		else if (pulse && !pad_pulse_q && pad_left > 0)
		begin
			pad_shift = pad_shift << 1;
			pad_left  = pad_left - 1;
		end
		// Line is active low and idles high
		if (pad_left > 0)
			data <= ~pad_shift[pad_bits-1];
		else
			data <= 1'b1;
		pad_pulse_q = pulse;
	end

	always @(negedge clk_50M)
	begin
		if (arst_n)
		begin
			cycle_no++;
			// New frame
			if (latch && !latch_q)
			begin
				// All pulse falls of the frame before
				if (latch_rises > 0)
					compare_count("pulse falls per frame", pad_bits, fall_count);
				latch_rises++;
				latch_len  = 0;
				fall_count = 0;
			end
			if (latch)
				latch_len++;
			if (!latch && latch_q)
				compare_count("latch high cycles", latch_cycles, latch_len);
			if (!pulse && pulse_q)
			begin
				fall_count++;
				low_len         = 0;
				last_fall_cycle = cycle_no;
			end
			if (!pulse)
				low_len++;
			if (pulse && !pulse_q)
				compare_count("pulse low cycles", half_cycles, low_len);
			if (frame_valid)
			begin
				frames_seen++;
				compare_count("pulse falls before frame_valid", pad_bits, fall_count);
				compare_count("frame_valid delay", valid_delay, cycle_no - last_fall_cycle);
				compare_count("frame_valid per latch", latch_rises, frames_seen);
			end
			else
				compare_byte("buttons between frames", held_buttons, buttons);
		end
		latch_q = latch;
		pulse_q = pulse;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and result checks
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		arst_n = 1'b0;
		data   = 1'b1;
		build_table();
		pad_pattern = stim_pattern[0];
		repeat (reset_cycles) @(negedge clk_50M);
		// Reset values
		compare_count("latch", 0, int'(latch));
		compare_count("pulse", 1, int'(pulse));
		compare_count("frame_valid", 0, int'(frame_valid));
		compare_byte("buttons", 8'h00, buttons);
		compare_byte("pressed", 8'h00, pressed);
		compare_byte("released", 8'h00, released);
		arst_n = 1'b1;
		for (int i = 0; i < entries; i++)
		begin
			@(negedge clk_50M);
			while (!frame_valid)
				@(negedge clk_50M);
			compare_byte("buttons", exp_buttons[i], buttons);
			compare_byte("pressed", exp_pressed[i], pressed);
			compare_byte("released", exp_released[i], released);
			held_buttons = exp_buttons[i];
			// Next pattern is loaded at the next latch
			if (i + 1 < entries)
				pad_pattern = stim_pattern[i + 1];
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog allows two spare frames beyond the table
	initial
	begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== verif/nes_pad_assert.sv ====
`timescale 1ns/1ps

module nes_pad_assert (
	input logic                                clk_50M,
	input logic                                arst_n,
	input logic                                latch,
	input logic                                pulse,
	input logic [nes_timing_pkg::pad_bits-1:0] pressed,
	input logic [nes_timing_pkg::pad_bits-1:0] released,
	input logic                                frame_valid
);

	////////////////////////////////////////////////////////////////////////////
	// Pad link and output protocol
	////////////////////////////////////////////////////////////////////////////

	// Pulse parked high while the pad loads
	pulse_high_in_latch: assert property (
		@(posedge clk_50M) disable iff (!arst_n) latch |-> pulse
	) else $error("pulse went low while latch was high");

	// Single cycle strobe
	frame_valid_one_cycle: assert property (
		@(posedge clk_50M) disable iff (!arst_n) frame_valid |=> !frame_valid
	) else $error("frame_valid stayed high for more than one cycle");

	// A button cannot rise and fall in one frame
	masks_disjoint: assert property (
		@(posedge clk_50M) disable iff (!arst_n) (pressed & released) == '0
	) else $error("pressed and released share a set bit");

	// Masks only alongside frame_valid
	masks_idle: assert property (
		@(posedge clk_50M) disable iff (!arst_n)
		!frame_valid |-> (pressed == '0 && released == '0)
	) else $error("pressed or released nonzero while frame_valid is low");

endmodule

bind nes_pad_top nes_pad_assert assert_i (
	.clk_50M     (clk_50M),
	.arst_n      (arst_n),
	.latch       (latch),
	.pulse       (pulse),
	.pressed     (pressed),
	.released    (released),
	.frame_valid (frame_valid)
);

// ==== src/nes_pad_top.sv ====
`timescale 1ns/1ps

module nes_pad_top #(
	parameter int unsigned poll_cycles = nes_timing_pkg::poll_cycles_default
) (
	input  logic                                clk_50M,
	input  logic                                arst_n,
	input  logic                                data,
	output logic                                latch,
	output logic                                pulse,
	output logic [nes_timing_pkg::pad_bits-1:0] buttons,
	output logic [nes_timing_pkg::pad_bits-1:0] pressed,
	output logic [nes_timing_pkg::pad_bits-1:0] released,
	output logic                                frame_valid
);

	import nes_timing_pkg::*;

	// Sequencer to capture
	logic                sample;
	logic                last;

	// Capture to events
	logic [pad_bits-1:0] frame_word;
	logic                frame_done;

	// Latch, pulse and sample strobes
	nes_poll_sequencer #(
		.poll_cycles (poll_cycles)
	) seq_i (
		.clk_50M (clk_50M),
		.arst_n  (arst_n),
		.latch   (latch),
		.pulse   (pulse),
		.sample  (sample),
		.last    (last)
	);

	// Serial data into a frame word
	nes_serial_capture cap_i (
		.clk_50M    (clk_50M),
		.arst_n     (arst_n),
		.data       (data),
		.sample     (sample),
		.last       (last),
		.frame_word (frame_word),
		.frame_done (frame_done)
	);

	// Held buttons and press/release events
	nes_button_events evt_i (
		.clk_50M     (clk_50M),
		.arst_n      (arst_n),
		.frame_word  (frame_word),
		.frame_done  (frame_done),
		.buttons     (buttons),
		.pressed     (pressed),
		.released    (released),
		.frame_valid (frame_valid)
	);

endmodule

// ==== src/nes_button_events.sv ====
`timescale 1ns/1ps

module nes_button_events (
	input  logic                                clk_50M,
	input  logic                                arst_n,
	input  logic [nes_timing_pkg::pad_bits-1:0] frame_word,
	input  logic                                frame_done,
	output logic [nes_timing_pkg::pad_bits-1:0] buttons,
	output logic [nes_timing_pkg::pad_bits-1:0] pressed,
	output logic [nes_timing_pkg::pad_bits-1:0] released,
	output logic                                frame_valid
);

	import nes_timing_pkg::*;

	// Edges of the new frame against the held one
	logic [pad_bits-1:0] rise_mask;
	logic [pad_bits-1:0] fall_mask;

	assign rise_mask = frame_word & ~buttons;
	assign fall_mask = buttons & ~frame_word;

	////////////////////////////////////////////////////////////////////////////
	// Held state and one-cycle event masks
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			buttons     <= '0;
			pressed     <= '0;
			released    <= '0;
			frame_valid <= 1'b0;
		end
		else if (frame_done)
		begin
			buttons     <= frame_word;
			pressed     <= rise_mask;
			released    <= fall_mask;
			frame_valid <= 1'b1;
		end
		else
		begin
			// Masks only live alongside frame_valid
			pressed     <= '0;
			released    <= '0;
			frame_valid <= 1'b0;
		end
	end

endmodule

// ==== src/nes_serial_capture.sv ====
`timescale 1ns/1ps

module nes_serial_capture (
	input  logic                                clk_50M,
	input  logic                                arst_n,
	input  logic                                data,
	input  logic                                sample,
	input  logic                                last,
	output logic [nes_timing_pkg::pad_bits-1:0] frame_word,
	output logic                                frame_done
);

	import nes_timing_pkg::*;
	import nes_pad_pkg::*;

	// Synchronizer stages
	logic                data_meta;
	logic                data_sync;

	// Working word and the slot for the next bit
	logic [pad_bits-1:0] work_word;
	logic [pad_bits-1:0] word_nxt;
	button_e             slot;

	////////////////////////////////////////////////////////////////////////////
	// Pad data synchronizer
	////////////////////////////////////////////////////////////////////////////

	// Idle pad line is high, no button pressed
	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end
		else
		begin
			data_meta <= data;
			data_sync <= data_meta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bit collection
	////////////////////////////////////////////////////////////////////////////

	// Active-low line, a pressed button reads as one
	always_comb
	begin
		word_nxt       = work_word;
		word_nxt[slot] = ~data_sync;
	end

	// Slot walks from A down to Right and wraps back for the next frame
	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
			slot <= btn_a;
		else if (sample)
			slot <= button_e'(slot - 3'd1);
	end

	always_ff @(posedge clk_50M)
	begin
		if (sample)
			work_word <= word_nxt;
	end

	// Completed word includes the bit taken with last
	always_ff @(posedge clk_50M)
	begin
		if (sample && last)
			frame_word <= word_nxt;
	end

	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
			frame_done <= 1'b0;
		else
			frame_done <= sample && last;
	end

endmodule

// ==== src/nes_poll_sequencer.sv ====
`timescale 1ns/1ps

module nes_poll_sequencer #(
	parameter int unsigned poll_cycles = nes_timing_pkg::poll_cycles_default
) (
	input  logic clk_50M,
	input  logic arst_n,
	output logic latch,
	output logic pulse,
	output logic sample,
	output logic last
);

	import nes_timing_pkg::*;
	import nes_pad_pkg::*;

	// Frame counter
	logic [frame_count_width-1:0] frame_cnt;
	logic                         frame_wrap;

	// State, phase timer and bit counter
	poll_state_e                  state;
	poll_state_e                  state_nxt;
	logic [phase_count_width-1:0] phase_cnt;
	logic [phase_count_width-1:0] phase_nxt;
	logic [2:0]                   bit_cnt;
	logic [2:0]                   bit_nxt;

	// Strobes for the next cycle
	logic                         sample_nxt;
	logic                         last_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Poll period timer
	////////////////////////////////////////////////////////////////////////////

	assign frame_wrap = (frame_cnt == frame_count_width'(poll_cycles - 1));

	// Starts at the wrap value so frame 0 begins on the first clock out of reset
	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
			frame_cnt <= frame_count_width'(poll_cycles - 1);
		else if (frame_wrap)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// State machine next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		phase_nxt = phase_cnt + 1'b1;
		bit_nxt   = bit_cnt;
		case (state)
			st_wait:
			begin
				// Phase timer and bit counter parked at zero
				phase_nxt = '0;
				bit_nxt   = '0;
				if (frame_wrap)
					state_nxt = st_latch;
			end
			st_latch:
			begin
				if (phase_cnt == phase_count_width'(latch_cycles - 1))
				begin
					state_nxt = st_clk_low;
					phase_nxt = '0;
				end
			end
			st_clk_low:
			begin
				if (phase_cnt == phase_count_width'(half_cycles - 1))
				begin
					state_nxt = st_clk_high;
					phase_nxt = '0;
				end
			end
			st_clk_high:
			begin
				if (phase_cnt == phase_count_width'(half_cycles - 1))
				begin
					phase_nxt = '0;
					// Eighth high phase ends the frame
					if (bit_cnt == 3'(pad_bits - 1))
						state_nxt = st_wait;
					else
					begin
						state_nxt = st_clk_low;
						bit_nxt   = bit_cnt + 1'b1;
					end
				end
			end
			default:
			begin
				state_nxt = st_wait;
				phase_nxt = '0;
				bit_nxt   = '0;
			end
		endcase
	end

	// Sample on entry to every low phase, last on the eighth one
	assign sample_nxt = (state_nxt == st_clk_low) && (state != st_clk_low);
	assign last_nxt   = sample_nxt && (bit_nxt == 3'(pad_bits - 1));

	////////////////////////////////////////////////////////////////////////////
	// State and output registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= st_wait;
			phase_cnt <= '0;
			bit_cnt   <= '0;
		end
		else
		begin
			state     <= state_nxt;
			phase_cnt <= phase_nxt;
			bit_cnt   <= bit_nxt;
		end
	end

	// Pad pins come straight from flops
	always_ff @(posedge clk_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			latch  <= 1'b0;
			pulse  <= 1'b1;
			sample <= 1'b0;
			last   <= 1'b0;
		end
		else
		begin
			latch  <= (state_nxt == st_latch);
			pulse  <= (state_nxt != st_clk_low);
			sample <= sample_nxt;
			last   <= last_nxt;
		end
	end

endmodule

// ==== src/nes_pad_pkg.sv ====
package nes_pad_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Button vector layout
	////////////////////////////////////////////////////////////////////////////

	// Bit positions in the button vector
	// A is shifted out first and sits in the top bit
	typedef enum logic [2:0]
	{
		btn_right  = 3'd0,
		btn_left   = 3'd1,
		btn_down   = 3'd2,
		btn_up     = 3'd3,
		btn_start  = 3'd4,
		btn_select = 3'd5,
		btn_b      = 3'd6,
		btn_a      = 3'd7
	} button_e;

	////////////////////////////////////////////////////////////////////////////
	// Poll sequencer states
	////////////////////////////////////////////////////////////////////////////

	// Idle until frame start, latch, then eight low/high pulse pairs
	typedef enum logic [1:0]
	{
		// Pulse parked high, waiting for the frame counter to wrap
		st_wait     = 2'd0,
		// Latch high, pad loads its shift register
		st_latch    = 2'd1,
		// Pulse low, the current bit is sampled on entry
		st_clk_low  = 2'd2,
		// Pulse high, pad shifts to the next bit on entry
		st_clk_high = 2'd3
	} poll_state_e;

endpackage

// ==== src/nes_timing_pkg.sv ====
package nes_timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Board clock and pad poll rate
	////////////////////////////////////////////////////////////////////////////

	// Board oscillator
	localparam int unsigned clk_freq_hz = 50_000_000;

	// One pad read per video frame
	localparam int unsigned poll_rate_hz = 60;

	////////////////////////////////////////////////////////////////////////////
	// Derived clock counts
	////////////////////////////////////////////////////////////////////////////

	// Latch high for 12 us
	localparam int unsigned latch_cycles = (clk_freq_hz / 1_000_000) * 12;

	// Each pulse half period is 6 us
	localparam int unsigned half_cycles = (clk_freq_hz / 1_000_000) * 6;

	// Rounded up, so the counter wraps at 833333
	localparam int unsigned poll_cycles_default =
		(clk_freq_hz + poll_rate_hz - 1) / poll_rate_hz;

	// Wide enough for the default frame
	localparam int unsigned frame_count_width = $clog2(poll_cycles_default);

	// Phase timer covers the longest phase, the latch
	localparam int unsigned phase_count_width = $clog2(latch_cycles);

	// Buttons on one pad
	localparam int unsigned pad_bits = 8;

endpackage
